/* vr_pkg.sv */
`default_nettype none

package vr_pkg;

    localparam int VIEW_W        = 16;
    localparam int OP_NUM_W      = 16;
    localparam int PAYLOAD_W     = 32;
    localparam int REPLICA_IDX_W = 4;
    localparam int LOG_DEPTH     = 16;
    localparam int LOG_ADDR_W    = 4;  // Low bits of the op number

    typedef enum logic [1:0] {
        MSG_SETUP,
        MSG_PREPARE,
        MSG_COMMIT,
        MSG_LOG_QUERY
    } msg_type_e;

    typedef enum logic [1:0] {
        RPL_SETUP_ACK,
        RPL_PREPARE_OK,
        RPL_PREPARE_NACK,
        RPL_LOG_ENTRY
    } reply_type_e;

    typedef struct packed {
        msg_type_e                msg_type;
        logic [VIEW_W-1:0]        view;
        logic [OP_NUM_W-1:0]      op_num;
        logic [PAYLOAD_W-1:0]     payload;
    } vr_msg_t;

    typedef struct packed {
        logic [VIEW_W-1:0]        view;
        logic [OP_NUM_W-1:0]      op_num;
        logic [OP_NUM_W-1:0]      commit_num;
    } vr_state_t;

    typedef struct packed {
        logic                     val;
        vr_state_t                state;
    } state_wr_t;

    typedef struct packed {
        logic [VIEW_W-1:0]        view;
        logic [OP_NUM_W-1:0]      op_num;
        logic [PAYLOAD_W-1:0]     payload;
    } log_entry_hdr_t;

    typedef struct packed {
        reply_type_e              reply_type;
        logic [VIEW_W-1:0]        view;
        logic [OP_NUM_W-1:0]      op_num;
        logic [OP_NUM_W-1:0]      commit_num;
        logic [REPLICA_IDX_W-1:0] replica_idx;
        logic [PAYLOAD_W-1:0]     payload;
    } vr_reply_t;

endpackage

`default_nettype wire

/* vr_state_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module vr_state_regs (
    input  wire logic                             clk,
    input  wire logic                             arst_n,
    input  wire vr_pkg::state_wr_t                setup_wr,
    input  wire vr_pkg::state_wr_t                repl_wr,
    input  wire logic                             cfg_wr,
    input  wire logic [vr_pkg::REPLICA_IDX_W-1:0] cfg_replica_idx,
    output vr_pkg::vr_state_t                     state,
    output logic [vr_pkg::REPLICA_IDX_W-1:0]      replica_idx
);
    import vr_pkg::*;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= '0;
        end else if (setup_wr.val) begin
            state <= setup_wr.state;  // Setup overrides the replication engine
        end else if (repl_wr.val) begin
            state <= repl_wr.state;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            replica_idx <= '0;
        end else if (cfg_wr) begin
            replica_idx <= cfg_replica_idx;
        end
    end

    // Only one engine runs at a time, so the writers never collide
    a_single_writer: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(setup_wr.val && repl_wr.val)
    ) else $error("state_regs: setup and replication writes in the same cycle");

    a_commit_le_op: assert property (
        @(posedge clk) disable iff (!arst_n)
        state.commit_num <= state.op_num
    ) else $error("state_regs: commit_num %0h above op_num %0h",
                  state.commit_num, state.op_num);

endmodule

`default_nettype wire

/* vr_log_hdr_mem.sv */
`timescale 1ns/10ps
`default_nettype none

module vr_log_hdr_mem (
    input  wire logic                          clk,
    input  wire logic                          wr_en,
    input  wire logic [vr_pkg::LOG_ADDR_W-1:0] wr_addr,
    input  wire vr_pkg::log_entry_hdr_t        wr_data,
    input  wire logic                          rd_en,
    input  wire logic [vr_pkg::LOG_ADDR_W-1:0] rd_addr,
    output vr_pkg::log_entry_hdr_t             rd_data
);
    import vr_pkg::*;

    log_entry_hdr_t mem [LOG_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];  // Old data when reading the address being written
        end
    end

endmodule

`default_nettype wire

/* vr_setup_eng.sv */
`timescale 1ns/10ps
`default_nettype none

module vr_setup_eng (
    input  wire logic                         clk,
    input  wire logic                         arst_n,
    input  wire logic                         start,
    input  wire vr_pkg::vr_msg_t              msg,
    input  wire logic                         reply_rdy,
    output vr_pkg::state_wr_t                 setup_wr,
    output logic                              cfg_wr,
    output logic [vr_pkg::REPLICA_IDX_W-1:0]  cfg_replica_idx,
    output logic                              reply_val,
    output vr_pkg::vr_reply_t                 reply,
    output logic                              done
);
    import vr_pkg::*;

    typedef enum logic {
        SETUP_IDLE,
        SETUP_REPLY
    } setup_fsm_e;

    setup_fsm_e fsm_q;
    logic       go;

    assign go = start && (fsm_q == SETUP_IDLE);

    // A new view starts with an empty log
    always_comb begin
        setup_wr            = '0;
        setup_wr.val        = go;
        setup_wr.state.view = msg.view;
    end

    assign cfg_wr          = go;
    assign cfg_replica_idx = msg.payload[REPLICA_IDX_W-1:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fsm_q <= SETUP_IDLE;
        end else if (go) begin
            fsm_q <= SETUP_REPLY;
        end else if (reply_val && reply_rdy) begin
            fsm_q <= SETUP_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            reply.reply_type  <= RPL_SETUP_ACK;
            reply.view        <= msg.view;
            reply.op_num      <= '0;
            reply.commit_num  <= '0;
            reply.replica_idx <= msg.payload[REPLICA_IDX_W-1:0];
            reply.payload     <= '0;
        end
    end

    assign reply_val = (fsm_q == SETUP_REPLY);
    assign done      = reply_val && reply_rdy;

endmodule

`default_nettype wire

/* vr_repl_eng.sv */
`timescale 1ns/10ps
`default_nettype none

module vr_repl_eng (
    input  wire logic                             clk,
    input  wire logic                             arst_n,
    input  wire logic                             start,
    input  wire vr_pkg::vr_msg_t                  msg,
    input  wire vr_pkg::vr_state_t                state,
    input  wire logic [vr_pkg::REPLICA_IDX_W-1:0] replica_idx,
    input  wire logic                             reply_rdy,
    output vr_pkg::state_wr_t                     repl_wr,
    output logic                                  log_wr_en,
    output logic [vr_pkg::LOG_ADDR_W-1:0]         log_wr_addr,
    output vr_pkg::log_entry_hdr_t                log_wr_data,
    output logic                                  log_rd_en,
    output logic [vr_pkg::LOG_ADDR_W-1:0]         log_rd_addr,
    input  wire vr_pkg::log_entry_hdr_t           log_rd_data,
    output logic                                  reply_val,
    output vr_pkg::vr_reply_t                     reply,
    output logic                                  done
);
    import vr_pkg::*;

    typedef enum logic [1:0] {
        REPL_IDLE,
        REPL_RD_WAIT,
        REPL_REPLY
    } repl_fsm_e;

    repl_fsm_e           fsm_q;
    logic                go;
    logic                is_prepare;
    logic                is_commit;
    logic                is_query;
    logic                prep_ok;
    logic                commit_ok;
    logic [OP_NUM_W-1:0] op_next;
    logic [OP_NUM_W-1:0] commit_cap;
    logic [OP_NUM_W-1:0] commit_new;

    assign go         = start && (fsm_q == REPL_IDLE);
    assign is_prepare = (msg.msg_type == MSG_PREPARE);
    assign is_commit  = (msg.msg_type == MSG_COMMIT);
    assign is_query   = (msg.msg_type == MSG_LOG_QUERY);

    assign op_next    = state.op_num + OP_NUM_W'(1);  // Wraps at 2^16
    assign prep_ok    = (msg.view == state.view) && (msg.op_num == op_next);
    assign commit_ok  = (msg.view == state.view);
    // Commit can never pass what has been prepared, and never moves back
    assign commit_cap = (msg.op_num < state.op_num) ? msg.op_num : state.op_num;
    assign commit_new = (commit_cap > state.commit_num) ? commit_cap : state.commit_num;

    always_comb begin
        repl_wr       = '0;
        repl_wr.state = state;
        if (go && is_prepare && prep_ok) begin
            repl_wr.val          = 1'b1;
            repl_wr.state.op_num = msg.op_num;
        end else if (go && is_commit && commit_ok) begin
            repl_wr.val              = 1'b1;
            repl_wr.state.commit_num = commit_new;
        end
    end

    assign log_wr_en   = go && is_prepare && prep_ok;
    assign log_wr_addr = msg.op_num[LOG_ADDR_W-1:0];
    assign log_wr_data = '{view: msg.view, op_num: msg.op_num, payload: msg.payload};
    assign log_rd_en   = go && is_query;
    assign log_rd_addr = msg.op_num[LOG_ADDR_W-1:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fsm_q <= REPL_IDLE;
        end else begin
            case (fsm_q)
                REPL_IDLE: begin
                    if (go && is_prepare) begin
                        fsm_q <= REPL_REPLY;
                    end else if (go && is_query) begin
                        fsm_q <= REPL_RD_WAIT;
                    end
                end
                REPL_RD_WAIT: fsm_q <= REPL_REPLY;
                REPL_REPLY: begin
                    if (reply_rdy) begin
                        fsm_q <= REPL_IDLE;
                    end
                end
                default: fsm_q <= REPL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (go && is_prepare) begin
            reply.reply_type  <= prep_ok ? RPL_PREPARE_OK : RPL_PREPARE_NACK;
            reply.view        <= state.view;
            reply.op_num      <= prep_ok ? msg.op_num : state.op_num;
            reply.commit_num  <= state.commit_num;
            reply.replica_idx <= replica_idx;
            reply.payload     <= '0;
        end else if (fsm_q == REPL_RD_WAIT) begin
            reply.reply_type  <= RPL_LOG_ENTRY;  // Read data is valid in this cycle
            reply.view        <= log_rd_data.view;
            reply.op_num      <= log_rd_data.op_num;
            reply.commit_num  <= state.commit_num;
            reply.replica_idx <= replica_idx;
            reply.payload     <= log_rd_data.payload;
        end
    end

    assign reply_val = (fsm_q == REPL_REPLY);
    assign done      = (reply_val && reply_rdy) || (go && is_commit);

    // The appended entry must show up as the new op_num in the register block
    a_log_append: assert property (
        @(posedge clk) disable iff (!arst_n)
        log_wr_en |-> repl_wr.val ##1 (state.op_num == $past(state.op_num) + OP_NUM_W'(1))
    ) else $error("repl_eng: log write without a matching op_num advance");

endmodule

`default_nettype wire

/* vr_msg_dispatch.sv */
`timescale 1ns/10ps
`default_nettype none

module vr_msg_dispatch (
    input  wire logic              clk,
    input  wire logic              arst_n,
    input  wire logic              msg_val,
    input  wire vr_pkg::vr_msg_t   msg,
    output logic                   msg_rdy,
    output vr_pkg::vr_msg_t        cur_msg,
    output logic                   setup_start,
    output logic                   repl_start,
    input  wire logic              setup_reply_val,
    input  wire vr_pkg::vr_reply_t setup_reply,
    input  wire logic              setup_done,
    output logic                   setup_reply_rdy,
    input  wire logic              repl_reply_val,
    input  wire vr_pkg::vr_reply_t repl_reply,
    input  wire logic              repl_done,
    output logic                   repl_reply_rdy,
    output logic                   reply_val,
    output vr_pkg::vr_reply_t      reply,
    input  wire logic              reply_rdy
);
    import vr_pkg::*;

    typedef enum logic [1:0] {
        DISP_IDLE,
        DISP_START,
        DISP_BUSY
    } disp_fsm_e;

    disp_fsm_e fsm_q;
    logic      sel_setup;
    logic      sel_done;

    assign msg_rdy  = (fsm_q == DISP_IDLE);
    assign sel_done = sel_setup ? setup_done : repl_done;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fsm_q     <= DISP_IDLE;
            sel_setup <= 1'b0;
        end else begin
            case (fsm_q)
                DISP_IDLE: begin
                    if (msg_val) begin
                        fsm_q     <= DISP_START;
                        sel_setup <= (msg.msg_type == MSG_SETUP);
                    end
                end
                DISP_START: fsm_q <= sel_done ? DISP_IDLE : DISP_BUSY;  // Commit ends here
                DISP_BUSY: begin
                    if (sel_done) begin
                        fsm_q <= DISP_IDLE;
                    end
                end
                default: fsm_q <= DISP_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (msg_val && msg_rdy) begin
            cur_msg <= msg;
        end
    end

    assign setup_start     = (fsm_q == DISP_START) && sel_setup;
    assign repl_start      = (fsm_q == DISP_START) && !sel_setup;
    assign setup_reply_rdy = sel_setup && reply_rdy;
    assign repl_reply_rdy  = !sel_setup && reply_rdy;
    assign reply_val       = sel_setup ? setup_reply_val : repl_reply_val;
    assign reply           = sel_setup ? setup_reply : repl_reply;

    a_no_reply_idle: assert property (
        @(posedge clk) disable iff (!arst_n)
        (fsm_q == DISP_IDLE) |-> !reply_val
    ) else $error("msg_dispatch: engine reply while no message is in flight");

endmodule

`default_nettype wire

/* vr_top.sv */
`timescale 1ns/10ps
`default_nettype none

module vr_top (
    input  wire logic              clk,
    input  wire logic              arst_n,
    input  wire logic              msg_val,
    input  wire vr_pkg::vr_msg_t   msg,
    output logic                   msg_rdy,
    output logic                   reply_val,
    output vr_pkg::vr_reply_t      reply,
    input  wire logic              reply_rdy
);
    import vr_pkg::*;

    vr_msg_t                  cur_msg;
    logic                     setup_start;
    logic                     repl_start;
    logic                     setup_reply_val;
    vr_reply_t                setup_reply;
    logic                     setup_done;
    logic                     setup_reply_rdy;
    logic                     repl_reply_val;
    vr_reply_t                repl_reply;
    logic                     repl_done;
    logic                     repl_reply_rdy;
    state_wr_t                setup_wr;
    state_wr_t                repl_wr;
    logic                     cfg_wr;
    logic [REPLICA_IDX_W-1:0] cfg_replica_idx;
    vr_state_t                state;
    logic [REPLICA_IDX_W-1:0] replica_idx;
    logic                     log_wr_en;
    logic [LOG_ADDR_W-1:0]    log_wr_addr;
    log_entry_hdr_t           log_wr_data;
    logic                     log_rd_en;
    logic [LOG_ADDR_W-1:0]    log_rd_addr;
    log_entry_hdr_t           log_rd_data;

    vr_msg_dispatch u_dispatch (
        .clk             (clk),
        .arst_n          (arst_n),
        .msg_val         (msg_val),
        .msg             (msg),
        .msg_rdy         (msg_rdy),
        .cur_msg         (cur_msg),
        .setup_start     (setup_start),
        .repl_start      (repl_start),
        .setup_reply_val (setup_reply_val),
        .setup_reply     (setup_reply),
        .setup_done      (setup_done),
        .setup_reply_rdy (setup_reply_rdy),
        .repl_reply_val  (repl_reply_val),
        .repl_reply      (repl_reply),
        .repl_done       (repl_done),
        .repl_reply_rdy  (repl_reply_rdy),
        .reply_val       (reply_val),
        .reply           (reply),
        .reply_rdy       (reply_rdy)
    );

    vr_setup_eng u_setup_eng (
        .clk             (clk),
        .arst_n          (arst_n),
        .start           (setup_start),
        .msg             (cur_msg),
        .reply_rdy       (setup_reply_rdy),
        .setup_wr        (setup_wr),
        .cfg_wr          (cfg_wr),
        .cfg_replica_idx (cfg_replica_idx),
        .reply_val       (setup_reply_val),
        .reply           (setup_reply),
        .done            (setup_done)
    );

    vr_repl_eng u_repl_eng (
        .clk         (clk),
        .arst_n      (arst_n),
        .start       (repl_start),
        .msg         (cur_msg),
        .state       (state),
        .replica_idx (replica_idx),
        .reply_rdy   (repl_reply_rdy),
        .repl_wr     (repl_wr),
        .log_wr_en   (log_wr_en),
        .log_wr_addr (log_wr_addr),
        .log_wr_data (log_wr_data),
        .log_rd_en   (log_rd_en),
        .log_rd_addr (log_rd_addr),
        .log_rd_data (log_rd_data),
        .reply_val   (repl_reply_val),
        .reply       (repl_reply),
        .done        (repl_done)
    );

    vr_state_regs u_state_regs (
        .clk             (clk),
        .arst_n          (arst_n),
        .setup_wr        (setup_wr),
        .repl_wr         (repl_wr),
        .cfg_wr          (cfg_wr),
        .cfg_replica_idx (cfg_replica_idx),
        .state           (state),
        .replica_idx     (replica_idx)
    );

    vr_log_hdr_mem u_log_hdr_mem (
        .clk     (clk),
        .wr_en   (log_wr_en),
        .wr_addr (log_wr_addr),
        .wr_data (log_wr_data),
        .rd_en   (log_rd_en),
        .rd_addr (log_rd_addr),
        .rd_data (log_rd_data)
    );

endmodule

`default_nettype wire

/* tb_vr_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_vr_top;
    import vr_pkg::*;

    localparam int TIMEOUT = 200;

    logic                     clk = 1'b0;
    logic                     arst_n;
    logic                     msg_val;
    vr_msg_t                  msg;
    logic                     msg_rdy;
    logic                     reply_val;
    vr_reply_t                reply;
    logic                     reply_rdy;

    logic [15:0]              lfsr;
    logic [VIEW_W-1:0]        m_view;
    logic [OP_NUM_W-1:0]      m_op;
    logic [OP_NUM_W-1:0]      m_commit;
    logic [REPLICA_IDX_W-1:0] m_ridx;
    log_entry_hdr_t           m_log [LOG_DEPTH];

    always #4 clk = ~clk;

    vr_top u_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .msg_val   (msg_val),
        .msg       (msg),
        .msg_rdy   (msg_rdy),
        .reply_val (reply_val),
        .reply     (reply),
        .reply_rdy (reply_rdy)
    );

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            fail_stop($sformatf("FAIL %s got %0h expected %0h", name, got, exp));
        end
    endtask

    // A held reply must not move until it is taken
    a_reply_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        reply_val && !reply_rdy |=> reply_val && $stable(reply)
    ) else fail_stop("reply changed while held by back-pressure");

    a_busy_while_reply: assert property (
        @(posedge clk) disable iff (!arst_n)
        reply_val |-> !msg_rdy
    ) else fail_stop("msg_rdy high while a reply is pending");

    task automatic wait_msg_rdy(input logic no_reply);
        int cycles;
        cycles = 0;
        while (!msg_rdy) begin
            if (no_reply) begin
                check_field("reply_val", reply_val, 32'h0);
            end
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                fail_stop("timeout while waiting for msg_rdy");
            end
        end
    endtask

    task automatic wait_reply_val();
        int cycles;
        cycles = 0;
        while (!reply_val) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                fail_stop("timeout while waiting for reply_val");
            end
        end
    endtask

    task automatic send_msg(input msg_type_e t, input logic [15:0] view,
                            input logic [15:0] op, input logic [31:0] payload);
        wait_msg_rdy(1'b0);
        msg_val = 1'b1;
        msg     = '{msg_type: t, view: view, op_num: op, payload: payload};
        @(posedge clk);
        @(negedge clk);
        msg_val = 1'b0;
        msg     = '0;
        check_field("msg_rdy", msg_rdy, 32'h0);  // Dropped right after acceptance
    endtask

    task automatic take_reply(input vr_reply_t exp);
        vr_reply_t   held;
        logic [31:0] gap;
        wait_reply_val();
        held = reply;
        rand_bits(3, gap);
        repeat (gap) begin
            @(negedge clk);
            check_field("reply_val", reply_val, 32'h1);
            check_field("msg_rdy", msg_rdy, 32'h0);
            check_field("reply_held", reply === held, 32'h1);
        end
        reply_rdy = 1'b1;
        check_field("reply.reply_type", reply.reply_type, exp.reply_type);
        check_field("reply.view", reply.view, exp.view);
        check_field("reply.op_num", reply.op_num, exp.op_num);
        check_field("reply.commit_num", reply.commit_num, exp.commit_num);
        check_field("reply.replica_idx", reply.replica_idx, exp.replica_idx);
        check_field("reply.payload", reply.payload, exp.payload);
        @(posedge clk);
        @(negedge clk);
        reply_rdy = 1'b0;
    endtask

    // Reference model update first, then the DUT transaction
    task automatic do_request(input msg_type_e t, input logic [15:0] view,
                              input logic [15:0] op, input logic [31:0] payload);
        vr_reply_t   exp;
        logic [15:0] cap;
        exp = '0;
        case (t)
            MSG_SETUP: begin
                m_view   = view;
                m_op     = '0;
                m_commit = '0;
                m_ridx   = payload[REPLICA_IDX_W-1:0];
                exp.reply_type  = RPL_SETUP_ACK;
                exp.view        = view;
                exp.replica_idx = m_ridx;
            end
            MSG_PREPARE: begin
                exp.view        = m_view;
                exp.commit_num  = m_commit;
                exp.replica_idx = m_ridx;
                if (view == m_view && op == m_op + 16'd1) begin
                    m_log[op[LOG_ADDR_W-1:0]] = '{view, op, payload};
                    m_op = op;
                    exp.reply_type = RPL_PREPARE_OK;
                end else begin
                    exp.reply_type = RPL_PREPARE_NACK;
                end
                exp.op_num = m_op;
            end
            MSG_COMMIT: begin
                if (view == m_view) begin
                    cap = (op < m_op) ? op : m_op;
                    if (cap > m_commit) begin
                        m_commit = cap;
                    end
                end
            end
            default: begin
                exp.reply_type  = RPL_LOG_ENTRY;
                exp.view        = m_log[op[LOG_ADDR_W-1:0]].view;
                exp.op_num      = m_log[op[LOG_ADDR_W-1:0]].op_num;
                exp.payload     = m_log[op[LOG_ADDR_W-1:0]].payload;
                exp.commit_num  = m_commit;
                exp.replica_idx = m_ridx;
            end
        endcase
        send_msg(t, view, op, payload);
        if (t == MSG_COMMIT) begin
            wait_msg_rdy(1'b1);  // Commit never replies
        end else begin
            take_reply(exp);
        end
    endtask

    task automatic prepare_range(input logic [15:0] view, input int first, input int last);
        logic [31:0] r;
        for (int i = first; i <= last; i++) begin
            rand_bits(32, r);
            do_request(MSG_PREPARE, view, 16'(i), r);
        end
    endtask

    initial begin
        logic [31:0] r;
        lfsr      = 16'd26696;
        arst_n    = 1'b0;
        msg_val   = 1'b0;
        msg       = '0;
        reply_rdy = 1'b0;
        m_view    = '0;
        m_op      = '0;
        m_commit  = '0;
        m_ridx    = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        check_field("reply_val", reply_val, 32'h0);
        check_field("msg_rdy", msg_rdy, 32'h1);

        do_request(MSG_COMMIT, 16'h0000, 16'h0005, 32'h0);

        rand_bits(32, r);
        do_request(MSG_SETUP, 16'h0003, 16'h0000, {r[31:4], 4'hA});
        prepare_range(16'h0003, 1, 6);

        rand_bits(32, r);
        do_request(MSG_PREPARE, 16'h0004, 16'h0007, r);  // Wrong view
        do_request(MSG_PREPARE, 16'h0003, 16'h0009, r);  // Skipped op number

        do_request(MSG_COMMIT, 16'h0003, 16'h0002, 32'h0);
        do_request(MSG_PREPARE, 16'h0003, 16'h0009, r);
        do_request(MSG_COMMIT, 16'h0005, 16'h0006, 32'h0);
        do_request(MSG_PREPARE, 16'h0003, 16'h0009, r);
        do_request(MSG_COMMIT, 16'h0003, 16'h0006, 32'h0);
        do_request(MSG_PREPARE, 16'h0003, 16'h0009, r);
        do_request(MSG_COMMIT, 16'h0003, 16'h0001, 32'h0);
        prepare_range(16'h0003, 7, 10);
        do_request(MSG_COMMIT, 16'h0003, 16'h0100, 32'h0);

        // Ops past 16 overwrite the oldest addresses
        prepare_range(16'h0003, 11, 21);
        for (int i = 0; i < LOG_DEPTH; i++) begin
            do_request(MSG_LOG_QUERY, 16'h0003, 16'(i), 32'h0);
        end

        rand_bits(32, r);
        do_request(MSG_SETUP, 16'h0007, 16'h0000, {r[31:4], 4'h5});
        prepare_range(16'h0007, 1, 1);
        do_request(MSG_LOG_QUERY, 16'h0007, 16'h0001, 32'h0);

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
vr_pkg.sv
vr_state_regs.sv
vr_log_hdr_mem.sv
vr_setup_eng.sv
vr_repl_eng.sv
vr_msg_dispatch.sv
vr_top.sv
tb_vr_top.sv

/* Bender.yml */
package:
  name: vr_core

sources:
  - vr_pkg.sv
  - vr_state_regs.sv
  - vr_log_hdr_mem.sv
  - vr_setup_eng.sv
  - vr_repl_eng.sv
  - vr_msg_dispatch.sv
  - vr_top.sv
  - target: test
    files:
      - tb_vr_top.sv
